/* Bender.yml */
package:
  name: ucode_engine

sources:
  - files:
      - logic/ucode_isa_pkg.sv
      - logic/ucode_ctrl_pkg.sv
      - logic/ucode_fetch.sv
      - logic/ucode_decode.sv
      - logic/ucode_execute.sv
      - logic/ucode_result.sv
      - logic/ucode_engine.sv
  - target: test
    files:
      - dv/ucode_engine_tb.sv

/* dv/ucode_engine_tb.sv */
// Microcode engine testbench
`timescale 1ns/100ps

module ucode_engine_tb
  import ucode_isa_pkg::*;
  import ucode_ctrl_pkg::*;
  ();

  localparam int pc_width_lp   = 6;
  localparam int imem_depth_lp = 1 << pc_width_lp;
  // length of the random body and address of the halt
  localparam int prog_len_lp   = 48;
  localparam int timeout_lp    = (prog_len_lp + 1) * 4 + 100;

  logic clk_i = 1'b0;
  logic reset_i;
  logic load_v_i;
  logic [pc_width_lp-1:0] load_addr_i;
  ucode_inst_s load_inst_i;
  logic run_i;
  logic hold_i;
  commit_s commit_o;
  flags_t flags_o;
  logic halted_o;

  integer seed;
  logic hold_en;
  logic [31:0] hold_rnd;
  string test_name;

  ucode_inst_s prog [imem_depth_lp];
  gpr_sel_t exp_gpr [imem_depth_lp];
  data_t exp_data [imem_depth_lp];
  int exp_count;
  flags_t exp_flags;
  int wr_idx;
  gpr_sel_t exp_gpr_cur;
  data_t exp_data_cur;

  ucode_engine #(.pc_width_p(pc_width_lp)) dut0 (
    .clk_i, .reset_i, .load_v_i, .load_addr_i, .load_inst_i
    , .run_i, .hold_i, .commit_o, .flags_o, .halted_o
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic report_value(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    report_fail($sformatf("ERR %s %s: expected %0h actual %0h", test_name, what, exp_v, act_v));
  endtask

  function automatic data_t alu_ref(input logic [3:0] minor, input data_t a, input data_t b,
                                    input imm_t imm);
    case (alu_minor_e'(minor))
      e_add_op:  return a + b;
      e_sub_op:  return a - b;
      e_lsh_op:  return a << b[3:0];
      e_rsh_op:  return a >> b[3:0];
      e_and_op:  return a & b;
      e_or_op:   return a | b;
      e_xor_op:  return a ^ b;
      e_neg_op:  return data_t'(0) - a;
      e_not_op:  return ~a;
      e_addi_op: return a + imm;
      e_subi_op: return a - imm;
      e_lshi_op: return a << imm[3:0];
      e_rshi_op: return a >> imm[3:0];
      default:   return a;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [3:0] minor, input data_t a, input data_t b,
                                      input imm_t imm);
    case (branch_minor_e'(minor))
      e_beq_op:  return a == b;
      e_bne_op:  return a != b;
      e_blt_op:  return a < b;
      e_ble_op:  return a <= b;
      e_beqi_op: return a == {8'h00, imm[15:8]};
      default:   return 1'b0;
    endcase
  endfunction

  // branches only jump forward so every path reaches the halt
  task automatic gen_program();
    logic [31:0] r;
    logic [31:0] r2;
    int kind;
    int span;
    for (int pc = 0; pc < imem_depth_lp; pc++) begin
      r = next_rand();
      r2 = next_rand();
      kind = int'(r % 32'd25);
      span = pc + 1 + int'(r2[1:0]);
      if (span > prog_len_lp) begin
        span = prog_len_lp;
      end
      prog[pc] = '0;
      prog[pc].dst = r[10:8];
      prog[pc].src_a = r[13:11];
      prog[pc].src_b = r[16:14];
      prog[pc].imm = r2[15:0];
      if (pc == prog_len_lp) begin
        prog[pc].op = e_op_halt;
      end else if (pc > prog_len_lp) begin
        // movi fill behind the halt must never commit
        prog[pc].op = e_op_reg_data;
        prog[pc].minor = e_movi_op;
        prog[pc].imm = imm_t'(pc);
      end else if (kind < 13) begin
        prog[pc].op = e_op_alu;
        prog[pc].minor = 4'(kind);
      end else if (kind < 15) begin
        prog[pc].op = e_op_reg_data;
        prog[pc].minor = 4'(kind - 13);
        // small movi values make the compares hit often
        if (kind == 14) begin
          prog[pc].imm = {12'h000, r2[3:0]};
        end
      end else if (kind < 20) begin
        prog[pc].op = e_op_branch;
        prog[pc].minor = 4'(kind - 15);
        prog[pc].imm = {4'h0, r2[11:8], 8'(span)};
      end else begin
        prog[pc].op = e_op_flag;
        prog[pc].minor = 4'(kind - 20);
        if (kind >= 23) begin
          prog[pc].imm[7:0] = 8'(span);
        end
      end
    end
  endtask

  // ISA level model that runs one instruction per step
  task automatic run_model();
    data_t regs [num_gpr_gp];
    data_t a;
    data_t b;
    data_t res;
    ucode_inst_s inst;
    int pc;
    logic wr;
    logic taken;
    logic done;
    for (int i = 0; i < num_gpr_gp; i++) begin
      regs[i] = '0;
    end
    exp_flags = '0;
    exp_count = 0;
    pc = 0;
    done = 1'b0;
    for (int step = 0; step < imem_depth_lp && !done; step++) begin
      inst = prog[pc];
      a = regs[inst.src_a];
      b = regs[inst.src_b];
      res = '0;
      wr = 1'b0;
      taken = 1'b0;
      case (inst.op)
        e_op_alu: begin
          wr = 1'b1;
          res = alu_ref(inst.minor, a, b, inst.imm);
        end
        e_op_branch: taken = branch_ref(inst.minor, a, b, inst.imm);
        e_op_reg_data: begin
          wr = 1'b1;
          res = (reg_minor_e'(inst.minor) == e_movi_op) ? inst.imm : a;
        end
        e_op_flag: begin
          case (flag_minor_e'(inst.minor))
            e_sf_op: exp_flags[inst.dst[1:0]] = inst.imm[0];
            e_andf_op: begin
              wr = 1'b1;
              res = {15'h0, exp_flags[inst.src_a[1:0]] & exp_flags[inst.src_b[1:0]]};
            end
            e_orf_op: begin
              wr = 1'b1;
              res = {15'h0, exp_flags[inst.src_a[1:0]] | exp_flags[inst.src_b[1:0]]};
            end
            e_bf_op:  taken = exp_flags[inst.src_a[1:0]];
            e_bfz_op: taken = ~exp_flags[inst.src_a[1:0]];
            default:  taken = 1'b0;
          endcase
        end
        e_op_halt: done = 1'b1;
        default: wr = 1'b0;
      endcase
      if (wr) begin
        regs[inst.dst] = res;
        exp_gpr[exp_count] = inst.dst;
        exp_data[exp_count] = res;
        exp_count++;
      end
      pc = taken ? int'(inst.imm[7:0]) : pc + 1;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    reset_i <= 1'b1;
    run_i <= 1'b0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
  endtask

  task automatic load_program();
    for (int addr = 0; addr < imem_depth_lp; addr++) begin
      @(posedge clk_i);
      load_v_i <= 1'b1;
      load_addr_i <= pc_width_lp'(addr);
      load_inst_i <= prog[addr];
    end
    @(posedge clk_i);
    load_v_i <= 1'b0;
  endtask

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (!halted_o && cycles < timeout_lp) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!halted_o) begin
      report_fail($sformatf("timeout, no halt within %0d cycles in %s", timeout_lp, test_name));
    end
  endtask

  // random stall level at roughly half duty
  always @(posedge clk_i) begin
    if (hold_en) begin
      hold_rnd = next_rand();
      hold_i <= hold_rnd[0];
    end else begin
      hold_i <= 1'b0;
    end
  end

  // walks the model write list as commits arrive
  always @(posedge clk_i) begin
    if (reset_i) begin
      wr_idx <= 0;
    end else if (commit_o.v) begin
      wr_idx <= wr_idx + 1;
    end
  end

  assign exp_gpr_cur  = exp_gpr[wr_idx];
  assign exp_data_cur = exp_data[wr_idx];

  reset_state_a: assert property (@(posedge clk_i)
      $fell(reset_i) |-> !commit_o.v && !halted_o && flags_o == '0)
    else report_fail($sformatf("engine not idle after reset in %s", test_name));

  commit_range_a: assert property (@(posedge clk_i) disable iff (reset_i)
      commit_o.v |-> wr_idx < exp_count)
    else report_fail($sformatf("more commits than model writes in %s", test_name));

  commit_gpr_a: assert property (@(posedge clk_i) disable iff (reset_i)
      commit_o.v && wr_idx < exp_count |-> commit_o.gpr == exp_gpr_cur)
    else report_value("commit gpr", 32'($sampled(exp_gpr_cur)), 32'($sampled(commit_o.gpr)));

  commit_data_a: assert property (@(posedge clk_i) disable iff (reset_i)
      commit_o.v && wr_idx < exp_count |-> commit_o.data == exp_data_cur)
    else report_value("commit data", 32'($sampled(exp_data_cur)), 32'($sampled(commit_o.data)));

  // a stalled cycle executes nothing
  hold_commit_a: assert property (@(posedge clk_i) disable iff (reset_i)
      hold_i |=> !commit_o.v)
    else report_fail($sformatf("commit right after a hold cycle in %s", test_name));

  halt_count_a: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(halted_o) |-> wr_idx == exp_count)
    else report_value("writes at halt", exp_count, $sampled(wr_idx));

  halt_flags_a: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(halted_o) |-> flags_o == exp_flags)
    else report_value("flags at halt", 32'($sampled(exp_flags)), 32'($sampled(flags_o)));

  halt_quiet_a: assert property (@(posedge clk_i) disable iff (reset_i)
      halted_o |-> !commit_o.v)
    else report_fail($sformatf("commit after halt in %s", test_name));

  halt_sticky_a: assert property (@(posedge clk_i) disable iff (reset_i)
      halted_o |=> halted_o)
    else report_fail($sformatf("halted_o dropped before reset in %s", test_name));

  initial begin
    seed = 28;
    reset_i = 1'b1;
    run_i = 1'b0;
    hold_i = 1'b0;
    load_v_i = 1'b0;
    load_addr_i = '0;
    load_inst_i = '0;
    hold_en = 1'b0;
    test_name = "reset";
    gen_program();
    run_model();
    apply_reset();
    load_program();

    test_name = "run";
    @(posedge clk_i);
    run_i <= 1'b1;
    wait_for_halt();
    repeat (5) @(posedge clk_i);

    // same program again under random stalls
    test_name = "hold_run";
    apply_reset();
    hold_en <= 1'b1;
    @(posedge clk_i);
    run_i <= 1'b1;
    wait_for_halt();
    hold_en <= 1'b0;
    repeat (5) @(posedge clk_i);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* logic/ucode_ctrl_pkg.sv */
// Microcode decoded control
package ucode_ctrl_pkg;

  import ucode_isa_pkg::*;

  typedef enum logic [3:0] {
    e_alu_add,
    e_alu_sub,
    e_alu_lsh,
    e_alu_rsh,
    e_alu_and,
    e_alu_or,
    e_alu_xor,
    e_alu_neg,
    e_alu_not,
    e_alu_pass
  } alu_op_e;

  // lt and le compare unsigned
  typedef enum logic [2:0] {
    e_br_none,
    e_br_eq,
    e_br_ne,
    e_br_lt,
    e_br_le,
    e_br_flag_set,
    e_br_flag_clear
  } branch_op_e;

  typedef enum logic [1:0] {
    e_src_b_gpr,
    e_src_b_imm,
    e_src_b_beqi_imm
  } src_b_sel_e;

  typedef enum logic [1:0] {
    e_src_a_gpr,
    e_src_a_flag,
    e_src_a_imm
  } src_a_sel_e;

  typedef struct packed {
    logic       v;
    target_t    pc_low;
    alu_op_e    alu_op;
    branch_op_e branch_op;
    src_a_sel_e src_a_sel;
    src_b_sel_e src_b_sel;
    gpr_sel_t   src_a;
    gpr_sel_t   src_b;
    gpr_sel_t   dst;
    imm_t       imm;
    target_t    target;
    logic       gpr_w_v;
    logic       flag_w_v;
    logic       flag_val;
    logic       halt;
  } decoded_s;

  typedef struct packed {
    logic    v;
    logic    halt;
    target_t target;
  } redirect_s;

  typedef struct packed {
    logic      gpr_w_v;
    gpr_sel_t  gpr;
    data_t     data;
    logic      flag_w_v;
    flag_sel_t flag_sel;
    logic      flag_val;
  } writeback_s;

  typedef struct packed {
    logic     v;
    gpr_sel_t gpr;
    data_t    data;
  } commit_s;

  typedef data_t [num_gpr_gp-1:0] gpr_file_t;

endpackage

/* logic/ucode_decode.sv */
// Microcode decode stage
`timescale 1ns/100ps

module ucode_decode
  import ucode_isa_pkg::*;
  import ucode_ctrl_pkg::*;
  #(parameter int pc_width_p = 6
  )
  (input                     clk_i
   , input                   reset_i
   , input  ucode_inst_s     inst_i
   , input  [pc_width_p-1:0] pc_i
   , input                   inst_v_i
   , input                   hold_i
   , input  redirect_s       redirect_i
   , output decoded_s        decoded_o
  );

  ucode_inst_s inst_r;
  logic [pc_width_p-1:0] pc_r;
  logic inst_v_r;

  // a stalled instruction stays in place and is replayed next cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inst_v_r <= 1'b0;
    end else if (~hold_i) begin
      // the instruction behind a taken branch or halt is squashed
      inst_v_r <= inst_v_i & ~redirect_i.v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (~hold_i) begin
      inst_r <= inst_i;
      pc_r   <= pc_i;
    end
  end

  always_comb begin
    decoded_o           = '0;
    decoded_o.v         = inst_v_r & ~hold_i;
    decoded_o.pc_low    = target_t'(pc_r);
    decoded_o.src_a     = inst_r.src_a;
    decoded_o.src_b     = inst_r.src_b;
    decoded_o.dst       = inst_r.dst;
    decoded_o.imm       = inst_r.imm;
    decoded_o.target    = inst_r.imm[7:0];
    decoded_o.flag_val  = inst_r.imm[0];

    case (inst_r.op)
      e_op_alu: begin
        decoded_o.gpr_w_v = 1'b1;
        case (alu_minor_e'(inst_r.minor))
          e_add_op: decoded_o.alu_op = e_alu_add;
          e_sub_op: decoded_o.alu_op = e_alu_sub;
          e_lsh_op: decoded_o.alu_op = e_alu_lsh;
          e_rsh_op: decoded_o.alu_op = e_alu_rsh;
          e_and_op: decoded_o.alu_op = e_alu_and;
          e_or_op:  decoded_o.alu_op = e_alu_or;
          e_xor_op: decoded_o.alu_op = e_alu_xor;
          e_neg_op: decoded_o.alu_op = e_alu_neg;
          e_not_op: decoded_o.alu_op = e_alu_not;
          e_addi_op: begin
            decoded_o.alu_op    = e_alu_add;
            decoded_o.src_b_sel = e_src_b_imm;
          end
          e_subi_op: begin
            decoded_o.alu_op    = e_alu_sub;
            decoded_o.src_b_sel = e_src_b_imm;
          end
          e_lshi_op: begin
            decoded_o.alu_op    = e_alu_lsh;
            decoded_o.src_b_sel = e_src_b_imm;
          end
          e_rshi_op: begin
            decoded_o.alu_op    = e_alu_rsh;
            decoded_o.src_b_sel = e_src_b_imm;
          end
          default: decoded_o.gpr_w_v = 1'b0;
        endcase
      end
      e_op_branch: begin
        case (branch_minor_e'(inst_r.minor))
          e_beq_op: decoded_o.branch_op = e_br_eq;
          e_bne_op: decoded_o.branch_op = e_br_ne;
          e_blt_op: decoded_o.branch_op = e_br_lt;
          e_ble_op: decoded_o.branch_op = e_br_le;
          e_beqi_op: begin
            decoded_o.branch_op = e_br_eq;
            decoded_o.src_b_sel = e_src_b_beqi_imm;
          end
          default: decoded_o.branch_op = e_br_none;
        endcase
      end
      e_op_reg_data: begin
        decoded_o.alu_op = e_alu_pass;
        case (reg_minor_e'(inst_r.minor))
          e_mov_op: decoded_o.gpr_w_v = 1'b1;
          e_movi_op: begin
            decoded_o.src_a_sel = e_src_a_imm;
            decoded_o.gpr_w_v   = 1'b1;
          end
          default: decoded_o.gpr_w_v = 1'b0;
        endcase
      end
      e_op_flag: begin
        // flag indices come from the low bits of dst, src_a and src_b
        decoded_o.src_a_sel = e_src_a_flag;
        case (flag_minor_e'(inst_r.minor))
          e_sf_op: decoded_o.flag_w_v = 1'b1;
          e_andf_op: begin
            decoded_o.alu_op  = e_alu_and;
            decoded_o.gpr_w_v = 1'b1;
          end
          e_orf_op: begin
            decoded_o.alu_op  = e_alu_or;
            decoded_o.gpr_w_v = 1'b1;
          end
          e_bf_op:  decoded_o.branch_op = e_br_flag_set;
          e_bfz_op: decoded_o.branch_op = e_br_flag_clear;
          default:  decoded_o.branch_op = e_br_none;
        endcase
      end
      e_op_halt: decoded_o.halt = 1'b1;
      default: begin
        // nop and unused opcodes leave every enable low
      end
    endcase
  end

endmodule

/* logic/ucode_engine.sv */
// Microcode engine top
`timescale 1ns/100ps

module ucode_engine
  import ucode_isa_pkg::*;
  import ucode_ctrl_pkg::*;
  #(parameter int pc_width_p = 6
  )
  (input                           clk_i
   , input                         reset_i
   , input                         load_v_i
   , input        [pc_width_p-1:0] load_addr_i
   , input  ucode_inst_s           load_inst_i
   , input                         run_i
   , input                         hold_i
   , output commit_s               commit_o
   , output flags_t                flags_o
   , output logic                  halted_o
  );

  ucode_inst_s fetch_inst;
  logic [pc_width_p-1:0] fetch_pc;
  logic fetch_v;
  decoded_s decoded;
  redirect_s redirect;
  writeback_s wb;
  gpr_file_t gpr;

  ucode_fetch #(.pc_width_p(pc_width_p)) fetch0 (
    .clk_i, .reset_i, .run_i, .hold_i, .load_v_i, .load_addr_i, .load_inst_i
    , .redirect_i(redirect)
    , .inst_o(fetch_inst), .pc_o(fetch_pc), .inst_v_o(fetch_v), .halted_o
  );

  ucode_decode #(.pc_width_p(pc_width_p)) decode0 (
    .clk_i, .reset_i, .inst_i(fetch_inst), .pc_i(fetch_pc), .inst_v_i(fetch_v)
    , .hold_i, .redirect_i(redirect), .decoded_o(decoded)
  );

  ucode_execute execute0 (
    .decoded_i(decoded), .gpr_i(gpr), .flags_i(flags_o)
    , .redirect_o(redirect), .wb_o(wb)
  );

  ucode_result result0 (
    .clk_i, .reset_i, .wb_i(wb), .gpr_o(gpr), .flags_o, .commit_o
  );

endmodule

/* logic/ucode_execute.sv */
// Microcode execute stage
`timescale 1ns/100ps

module ucode_execute
  import ucode_isa_pkg::*;
  import ucode_ctrl_pkg::*;
  (input  decoded_s     decoded_i
   , input  gpr_file_t  gpr_i
   , input  flags_t     flags_i
   , output redirect_s  redirect_o
   , output writeback_s wb_o
  );

  data_t op_a, op_b, alu_res;
  logic taken;

  // operand a
  always_comb begin
    case (decoded_i.src_a_sel)
      e_src_a_flag: op_a = data_t'(flags_i[decoded_i.src_a[1:0]]);
      e_src_a_imm:  op_a = decoded_i.imm;
      default:      op_a = gpr_i[decoded_i.src_a];
    endcase
  end

  // operand b, flag ops read both operands from the flag register
  always_comb begin
    if (decoded_i.src_a_sel == e_src_a_flag) begin
      op_b = data_t'(flags_i[decoded_i.src_b[1:0]]);
    end else begin
      case (decoded_i.src_b_sel)
        e_src_b_imm:      op_b = decoded_i.imm;
        e_src_b_beqi_imm: op_b = data_t'(decoded_i.imm[15:8]);
        default:          op_b = gpr_i[decoded_i.src_b];
      endcase
    end
  end

  always_comb begin
    case (decoded_i.alu_op)
      e_alu_add: alu_res = op_a + op_b;
      e_alu_sub: alu_res = op_a - op_b;
      e_alu_lsh: alu_res = op_a << op_b[3:0];
      e_alu_rsh: alu_res = op_a >> op_b[3:0];
      e_alu_and: alu_res = op_a & op_b;
      e_alu_or:  alu_res = op_a | op_b;
      e_alu_xor: alu_res = op_a ^ op_b;
      e_alu_neg: alu_res = -op_a;
      e_alu_not: alu_res = ~op_a;
      default:   alu_res = op_a;
    endcase
  end

  always_comb begin
    case (decoded_i.branch_op)
      e_br_eq:         taken = (op_a == op_b);
      e_br_ne:         taken = (op_a != op_b);
      e_br_lt:         taken = (op_a < op_b);
      e_br_le:         taken = (op_a <= op_b);
      e_br_flag_set:   taken = op_a[0];
      e_br_flag_clear: taken = ~op_a[0];
      default:         taken = 1'b0;
    endcase
  end

  // halt redirects fetch to itself so nothing past it issues
  assign redirect_o.v      = decoded_i.v & (taken | decoded_i.halt);
  assign redirect_o.halt   = decoded_i.v & decoded_i.halt;
  assign redirect_o.target = decoded_i.halt ? decoded_i.pc_low : decoded_i.target;

  assign wb_o.gpr_w_v  = decoded_i.v & decoded_i.gpr_w_v;
  assign wb_o.gpr      = decoded_i.dst;
  assign wb_o.data     = alu_res;
  assign wb_o.flag_w_v = decoded_i.v & decoded_i.flag_w_v;
  assign wb_o.flag_sel = decoded_i.dst[1:0];
  assign wb_o.flag_val = decoded_i.flag_val;

endmodule

/* logic/ucode_fetch.sv */
// Microcode fetch stage
`timescale 1ns/100ps

module ucode_fetch
  import ucode_isa_pkg::*;
  import ucode_ctrl_pkg::*;
  #(parameter int pc_width_p = 6
  )
  (input                           clk_i
   , input                         reset_i
   , input                         run_i
   , input                         hold_i
   , input                         load_v_i
   , input        [pc_width_p-1:0] load_addr_i
   , input  ucode_inst_s           load_inst_i
   , input  redirect_s             redirect_i
   , output ucode_inst_s           inst_o
   , output logic [pc_width_p-1:0] pc_o
   , output logic                  inst_v_o
   , output logic                  halted_o
  );

  localparam int depth_lp = 1 << pc_width_p;

  ucode_inst_s imem_r [depth_lp-1:0];
  logic [pc_width_p-1:0] fetch_pc_r, fetch_pc_n;
  logic halted_r;

  // program load port, only used while the engine is stopped
  always_ff @(posedge clk_i) begin
    if (load_v_i) begin
      imem_r[load_addr_i] <= load_inst_i;
    end
  end

  assign inst_o   = imem_r[fetch_pc_r];
  assign pc_o     = fetch_pc_r;
  assign inst_v_o = run_i & ~halted_r;
  assign halted_o = halted_r;

  // predict not taken, a redirect from execute overrides the sequential pc
  always_comb begin
    fetch_pc_n = fetch_pc_r;
    if (redirect_i.v) begin
      fetch_pc_n = redirect_i.target[pc_width_p-1:0];
    end else if (inst_v_o & ~hold_i) begin
      fetch_pc_n = fetch_pc_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_pc_r <= '0;
      halted_r   <= 1'b0;
    end else begin
      fetch_pc_r <= fetch_pc_n;
      // sticky until reset
      if (redirect_i.v & redirect_i.halt) begin
        halted_r <= 1'b1;
      end
    end
  end

endmodule

/* logic/ucode_isa_pkg.sv */
// Microcode instruction set
package ucode_isa_pkg;

  localparam int data_width_gp = 16;
  localparam int num_gpr_gp    = 8;
  localparam int num_flags_gp  = 4;

  typedef logic [data_width_gp-1:0] data_t;
  typedef logic [2:0]               gpr_sel_t;
  typedef logic [1:0]               flag_sel_t;
  typedef logic [num_flags_gp-1:0]  flags_t;
  typedef logic [15:0]              imm_t;
  typedef logic [7:0]               target_t;

  // major opcode, codes 6 and 7 are unused and behave as nop
  typedef enum logic [2:0] {
    e_op_nop      = 3'd0,
    e_op_alu      = 3'd1,
    e_op_branch   = 3'd2,
    e_op_reg_data = 3'd3,
    e_op_flag     = 3'd4,
    e_op_halt     = 3'd5
  } ucode_op_e;

  typedef enum logic [3:0] {
    e_add_op  = 4'd0,
    e_sub_op  = 4'd1,
    e_lsh_op  = 4'd2,
    e_rsh_op  = 4'd3,
    e_and_op  = 4'd4,
    e_or_op   = 4'd5,
    e_xor_op  = 4'd6,
    e_neg_op  = 4'd7,
    e_not_op  = 4'd8,
    e_addi_op = 4'd9,
    e_subi_op = 4'd10,
    e_lshi_op = 4'd11,
    e_rshi_op = 4'd12
  } alu_minor_e;

  typedef enum logic [3:0] {
    e_beq_op  = 4'd0,
    e_bne_op  = 4'd1,
    e_blt_op  = 4'd2,
    e_ble_op  = 4'd3,
    e_beqi_op = 4'd4
  } branch_minor_e;

  typedef enum logic [3:0] {
    e_mov_op  = 4'd0,
    e_movi_op = 4'd1
  } reg_minor_e;

  typedef enum logic [3:0] {
    e_sf_op   = 4'd0,
    e_andf_op = 4'd1,
    e_orf_op  = 4'd2,
    e_bf_op   = 4'd3,
    e_bfz_op  = 4'd4
  } flag_minor_e;

  // branches keep the target in imm[7:0] and the beqi value in imm[15:8]
  typedef struct packed {
    ucode_op_e  op;
    logic [3:0] minor;
    gpr_sel_t   dst;
    gpr_sel_t   src_a;
    gpr_sel_t   src_b;
    imm_t       imm;
  } ucode_inst_s;

endpackage

/* logic/ucode_result.sv */
// Microcode result stage
`timescale 1ns/100ps

module ucode_result
  import ucode_isa_pkg::*;
  import ucode_ctrl_pkg::*;
  (input                clk_i
   , input              reset_i
   , input  writeback_s wb_i
   , output gpr_file_t  gpr_o
   , output flags_t     flags_o
   , output commit_s    commit_o
  );

  gpr_file_t gpr_r;
  flags_t flags_r;
  commit_s commit_r;

  // architectural state, cleared so programs start from a known value
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpr_r   <= '0;
      flags_r <= '0;
    end else begin
      if (wb_i.gpr_w_v) begin
        gpr_r[wb_i.gpr] <= wb_i.data;
      end
      if (wb_i.flag_w_v) begin
        flags_r[wb_i.flag_sel] <= wb_i.flag_val;
      end
    end
  end

  // commit report trails the write by one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      commit_r.v <= 1'b0;
    end else begin
      commit_r.v <= wb_i.gpr_w_v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_i.gpr_w_v) begin
      commit_r.gpr  <= wb_i.gpr;
      commit_r.data <= wb_i.data;
    end
  end

  assign gpr_o    = gpr_r;
  assign flags_o  = flags_r;
  assign commit_o = commit_r;

endmodule

/* ucode_engine.f */
logic/ucode_isa_pkg.sv
logic/ucode_ctrl_pkg.sv
logic/ucode_fetch.sv
logic/ucode_decode.sv
logic/ucode_execute.sv
logic/ucode_result.sv
logic/ucode_engine.sv
dv/ucode_engine_tb.sv
